// File: rtl/bg_geom_pkg.sv
// Background renderer geometry
// Pixel, tile and scanline types shared by the fetcher and the mixer,
// plus the tile fetcher state encoding

package bg_geom_pkg;

	typedef logic [9:0]  pixel_coord_t;
	typedef logic [15:0] mem_addr_t;
	// Four 4bpp pixels, lowest nibble leftmost
	typedef logic [15:0] mem_word_t;
	typedef logic [7:0]  line_addr_t;
	typedef logic [7:0]  tile_num_t;
	// Palette high nibble above the pixel value
	typedef logic [7:0]  color_index_t;

	localparam tile_num_t TILE_TRANSPARENT = 8'hff;

	typedef enum logic [2:0] {
		fs_idle,
		fs_begin,
		fs_fetch_tile,
		fs_wait_tile,
		fs_fetch_data,
		fs_wait_data,
		fs_stream_data
	} fetch_state_t;

	// One write into a scanline buffer
	typedef struct packed {
		logic       wr;
		line_addr_t addr;
		mem_word_t  data;
	} line_wr_t;

endpackage

// File: rtl/bg_regs_pkg.sv
// Background renderer register map
// CPU register addresses of both layers and the layer configuration record

package bg_regs_pkg;

	typedef logic [3:0] reg_addr_t;

	// Layer 1
	localparam reg_addr_t REG_CTRL1     = 4'd0;
	localparam reg_addr_t REG_SCROLL_X1 = 4'd1;
	localparam reg_addr_t REG_SCROLL_Y1 = 4'd2;
	localparam reg_addr_t REG_MAP_ADDR1 = 4'd3;
	localparam reg_addr_t REG_SET_ADDR1 = 4'd4;

	// Layer 2
	localparam reg_addr_t REG_CTRL2     = 4'd5;
	localparam reg_addr_t REG_SCROLL_X2 = 4'd6;
	localparam reg_addr_t REG_SCROLL_Y2 = 4'd7;
	localparam reg_addr_t REG_MAP_ADDR2 = 4'd8;
	localparam reg_addr_t REG_SET_ADDR2 = 4'd9;

	typedef struct packed {
		logic        enable;
		logic [3:0]  pal_hi;
		logic [15:0] scroll_x;
		logic [15:0] scroll_y;
		// Word address, two tile numbers per word
		logic [15:0] map_addr;
		// Counted in units of four words
		logic [15:0] set_addr;
	} layer_cfg_t;

endpackage

// File: rtl/bg_reg_file.sv
// Background layer register file
// Write-only CPU port holding the configuration of both layers.
// Control register: bit 0 enable, bits 7..4 palette high nibble

`timescale 1ns/1ps

module bg_reg_file
	import bg_geom_pkg::*;
	import bg_regs_pkg::*;
(
	input  logic       CLK,
	input  logic       RSTb,
	input  reg_addr_t  address,
	input  mem_word_t  data_in,
	input  logic       wr,
	output layer_cfg_t cfg1,
	output layer_cfg_t cfg2
);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cfg1 <= '0;
			cfg2 <= '0;
		end else if (wr) begin
			case (address)
				REG_CTRL1: begin
					cfg1.enable <= data_in[0];
					cfg1.pal_hi <= data_in[7:4];
				end
				REG_SCROLL_X1:
					cfg1.scroll_x <= data_in;
				REG_SCROLL_Y1:
					cfg1.scroll_y <= data_in;
				REG_MAP_ADDR1:
					cfg1.map_addr <= data_in;
				REG_SET_ADDR1:
					cfg1.set_addr <= data_in;
				REG_CTRL2: begin
					cfg2.enable <= data_in[0];
					cfg2.pal_hi <= data_in[7:4];
				end
				REG_SCROLL_X2:
					cfg2.scroll_x <= data_in;
				REG_SCROLL_Y2:
					cfg2.scroll_y <= data_in;
				REG_MAP_ADDR2:
					cfg2.map_addr <= data_in;
				REG_SET_ADDR2:
					cfg2.set_addr <= data_in;
				// Addresses 10 to 15 are unmapped
				default: ;
			endcase
		end
	end

endmodule

// File: rtl/tile_fetcher.sv
// Background tile fetcher
// On each enabled horizontal tick, walks the tile map for the coming
// scanline, layer 1 then layer 2, reads the 16-pixel row of every
// visible tile and writes it into the active scanline buffer

`timescale 1ns/1ps

module tile_fetcher
	import bg_geom_pkg::*;
	import bg_regs_pkg::*;
#(
	parameter int RENDER_START = 32,
	parameter int RENDER_END   = 720
) (
	input  logic         CLK,
	input  logic         RSTb,
	input  logic         h_tick,
	input  layer_cfg_t   cfg1,
	input  layer_cfg_t   cfg2,
	input  pixel_coord_t display_y,
	output mem_addr_t    mem_addr,
	input  mem_word_t    mem_data,
	output logic         rvalid,
	input  logic         rready,
	output line_wr_t     line_wr,
	output logic         layer
);

	fetch_state_t state;
	pixel_coord_t line_y;
	pixel_coord_t render_x;
	// Byte index into the tile map
	logic [16:0]  map_index;
	tile_num_t    tile;
	logic [2:0]   burst_cnt;

	layer_cfg_t   cfg;
	logic [15:0]  y_pos;
	logic [16:0]  map_start;
	mem_addr_t    data_addr;

	assign cfg = layer ? cfg2 : cfg1;
	assign y_pos = cfg.scroll_y + 16'(line_y);

	// Map rows are 128 tiles wide and coarse scroll picks the first tile of the row
	assign map_start = {cfg.map_addr, 1'b0} + {3'b000, y_pos[10:4], cfg.scroll_x[10:4]};

	// 64 words per tile and 4 words per row
	assign data_addr = {cfg.set_addr[13:0], 2'b00}
		+ {2'b00, tile, 6'b000000}
		+ {10'h000, y_pos[3:0], 2'b00};

	assign rvalid = (state == fs_wait_tile) || (state == fs_wait_data);

	// Only the first row of the eight-word burst belongs to this line
	assign line_wr.wr   = (state == fs_stream_data) && !burst_cnt[2];
	assign line_wr.addr = render_x[9:2];
	assign line_wr.data = mem_data;

	always_ff @(posedge CLK) begin
		if (h_tick && cfg1.enable)
			line_y <= display_y;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state     <= fs_idle;
			layer     <= 1'b0;
			render_x  <= '0;
			map_index <= '0;
			mem_addr  <= '0;
			tile      <= '0;
			burst_cnt <= '0;
		end else if (h_tick && cfg1.enable) begin
			// New line restarts the walk from any state
			state <= fs_begin;
			layer <= 1'b0;
		end else begin
			case (state)
				fs_begin: begin
					map_index <= map_start;
					render_x  <= pixel_coord_t'(RENDER_START);
					state     <= fs_fetch_tile;
				end
				fs_fetch_tile: begin
					if (render_x == pixel_coord_t'(RENDER_END)) begin
						if (!layer && cfg2.enable) begin
							layer <= 1'b1;
							state <= fs_begin;
						end else begin
							state <= fs_idle;
						end
					end else begin
						mem_addr <= map_index[16:1];
						state    <= fs_wait_tile;
					end
				end
				fs_wait_tile: begin
					if (rready) begin
						tile  <= map_index[0] ? mem_data[15:8] : mem_data[7:0];
						state <= fs_fetch_data;
					end
				end
				fs_fetch_data: begin
					if (tile == TILE_TRANSPARENT) begin
						// Nothing to draw so the cleared words stay as they are
						render_x  <= render_x + 10'd16;
						map_index <= map_index + 17'd1;
						state     <= fs_fetch_tile;
					end else begin
						mem_addr <= data_addr;
						state    <= fs_wait_data;
					end
				end
				fs_wait_data: begin
					if (rready) begin
						burst_cnt <= '0;
						state     <= fs_stream_data;
					end
				end
				fs_stream_data: begin
					// Burst word k arrives while mem_addr holds base plus k
					mem_addr  <= mem_addr + 16'd1;
					burst_cnt <= burst_cnt + 3'd1;
					if (!burst_cnt[2])
						render_x <= render_x + 10'd4;
					if (burst_cnt == 3'd7) begin
						map_index <= map_index + 17'd1;
						state     <= fs_fetch_tile;
					end
				end
				default:
					state <= fs_idle;
			endcase
		end
	end

endmodule

// File: rtl/scanline_ram.sv
// Scanline buffer
// 256 x 16 simple dual-port block RAM, registered read

`timescale 1ns/1ps

module scanline_ram
	import bg_geom_pkg::*;
(
	input  logic       CLK,
	input  line_addr_t rd_addr,
	output mem_word_t  rd_data,
	input  line_wr_t   wr
);

	mem_word_t mem [256];

	// Block RAM powers up cleared
	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = '0;
	end

	always_ff @(posedge CLK) begin
		if (wr.wr)
			mem[wr.addr] <= wr.data;
		rd_data <= mem[rd_addr];
	end

endmodule

// File: rtl/scanline_mixer.sv
// Scanline mixer
// Two double-buffered scanline pairs, one per layer. The fetcher fills
// the active pair while the display pair is read with fine X scroll,
// cleared behind the read position and merged by layer priority

`timescale 1ns/1ps

module scanline_mixer
	import bg_geom_pkg::*;
	import bg_regs_pkg::*;
(
	input  logic         CLK,
	input  logic         RSTb,
	input  logic         h_tick,
	input  layer_cfg_t   cfg1,
	input  layer_cfg_t   cfg2,
	input  line_wr_t     line_wr,
	input  logic         layer,
	input  pixel_coord_t display_x,
	output color_index_t color_index
);

	logic         active_buf;
	logic         disp_buf_q;
	// Buffer index is {layer, pair}
	line_addr_t   rd_addr [4];
	mem_word_t    rd_data [4];
	line_wr_t     buf_wr  [4];
	pixel_coord_t read_x  [2];
	logic [1:0]   read_sub_q [2];
	logic [3:0]   pixel   [2];
	color_index_t merged;

	assign read_x[0] = display_x + pixel_coord_t'(cfg1.scroll_x[3:0]);
	assign read_x[1] = display_x + pixel_coord_t'(cfg2.scroll_x[3:0]);

	// Swap pairs in step with the fetcher restart
	always_ff @(posedge CLK) begin
		if (!RSTb)
			active_buf <= 1'b0;
		else if (h_tick && cfg1.enable)
			active_buf <= ~active_buf;
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			rd_addr[i] = '0;
			buf_wr[i]  = '0;
		end
		buf_wr[{layer, active_buf}] = line_wr;
		for (int l = 0; l < 2; l++) begin
			rd_addr[{l[0], ~active_buf}] = read_x[l][9:2];
			// Zero the word just passed
			buf_wr[{l[0], ~active_buf}].wr   = 1'b1;
			buf_wr[{l[0], ~active_buf}].addr = read_x[l][9:2] - 8'd1;
		end
	end

	for (genvar i = 0; i < 4; i++) begin : g_line
		scanline_ram u_ram (
			.CLK     (CLK),
			.rd_addr (rd_addr[i]),
			.rd_data (rd_data[i]),
			.wr      (buf_wr[i])
		);
	end

	// Track the read so the nibble matches the RAM output
	always_ff @(posedge CLK) begin
		disp_buf_q    <= ~active_buf;
		read_sub_q[0] <= read_x[0][1:0];
		read_sub_q[1] <= read_x[1][1:0];
	end

	always_comb begin
		for (int l = 0; l < 2; l++)
			pixel[l] = rd_data[{l[0], disp_buf_q}][{read_sub_q[l], 2'b00} +: 4];
		// Layer 2 shows through zero pixels of layer 1 when enabled
		if (pixel[0] != 4'd0 || !cfg2.enable)
			merged = {cfg1.pal_hi, pixel[0]};
		else
			merged = {cfg2.pal_hi, pixel[1]};
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			color_index <= '0;
		else
			color_index <= merged;
	end

endmodule

// File: rtl/bg_renderer.sv
// Two-layer tile background renderer
// Joins the CPU register file, the tile fetcher on the memory channel
// and the scanline mixer on the display side

`timescale 1ns/1ps

module bg_renderer
	import bg_geom_pkg::*;
	import bg_regs_pkg::*;
#(
	parameter int RENDER_START = 32,
	parameter int RENDER_END   = 720
) (
	input  logic         CLK,
	input  logic         RSTb,
	input  reg_addr_t    address,
	input  mem_word_t    data_in,
	input  logic         wr,
	input  logic         h_tick,
	input  pixel_coord_t display_x,
	input  pixel_coord_t display_y,
	output color_index_t color_index,
	output mem_addr_t    mem_addr,
	input  mem_word_t    mem_data,
	output logic         rvalid,
	input  logic         rready
);

	layer_cfg_t cfg1;
	layer_cfg_t cfg2;
	line_wr_t   line_wr;
	logic       layer;

	bg_reg_file u_regs (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.address (address),
		.data_in (data_in),
		.wr      (wr),
		.cfg1    (cfg1),
		.cfg2    (cfg2)
	);

	tile_fetcher #(
		.RENDER_START (RENDER_START),
		.RENDER_END   (RENDER_END)
	) u_fetch (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.h_tick    (h_tick),
		.cfg1      (cfg1),
		.cfg2      (cfg2),
		.display_y (display_y),
		.mem_addr  (mem_addr),
		.mem_data  (mem_data),
		.rvalid    (rvalid),
		.rready    (rready),
		.line_wr   (line_wr),
		.layer     (layer)
	);

	scanline_mixer u_mix (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.h_tick      (h_tick),
		.cfg1        (cfg1),
		.cfg2        (cfg2),
		.line_wr     (line_wr),
		.layer       (layer),
		.display_x   (display_x),
		.color_index (color_index)
	);

endmodule

// File: testbench/bg_renderer_sva.sv
// Tile fetcher memory channel assertions
// Bound into every tile_fetcher instance

`timescale 1ns/1ps

module fetch_channel_sva
	import bg_geom_pkg::*;
(
	input logic         CLK,
	input logic         RSTb,
	input logic         rvalid,
	input logic         rready,
	input mem_addr_t    mem_addr,
	input fetch_state_t state,
	input line_wr_t     line_wr
);

	int fail_count = 0;

	// Request address held until the grant
	addr_stable: assert property (@(posedge CLK) disable iff (!RSTb)
		rvalid && !rready |=> $stable(mem_addr))
		else begin
			fail_count++;
			$error("mem_addr changed while a memory request was pending");
		end

	no_req_in_reset: assert property (@(posedge CLK) !RSTb |=> !rvalid)
		else begin
			fail_count++;
			$error("rvalid raised while reset was applied");
		end

	// Line writes begin only in the cycle after a data grant and never from idle
	write_after_grant: assert property (@(posedge CLK) disable iff (!RSTb)
		$rose(line_wr.wr) |-> $past(state == fs_wait_data && rready))
		else begin
			fail_count++;
			$error("scanline write started without a preceding data grant");
		end

endmodule

bind tile_fetcher fetch_channel_sva u_sva (
	.CLK      (CLK),
	.RSTb     (RSTb),
	.rvalid   (rvalid),
	.rready   (rready),
	.mem_addr (mem_addr),
	.state    (state),
	.line_wr  (line_wr)
);

// File: testbench/bg_renderer_tb.sv
// Background renderer testbench
// Random tile memory and layer setups, scanlines rendered by the DUT
// and checked pixel by pixel against a reference model

`timescale 1ns/1ps

module bg_renderer_tb
	import bg_geom_pkg::*;
	import bg_regs_pkg::*;
();

	localparam int CLK_PERIOD   = 4;
	localparam int RENDER_START = 32;
	localparam int RENDER_END   = 160;
	localparam int MAX_STALL    = 3;
	localparam int TILES        = (RENDER_END - RENDER_START) / 16;
	// Map read, data request and eight-word burst per tile, both layers
	localparam int FETCH_BOUND  = 2 * (TILES * (12 + 2 * MAX_STALL) + 2) + 8;
	// Sweep starts early and ends late so every buffer word gets cleared
	localparam int SWEEP_FIRST  = RENDER_START - 16;
	localparam int SWEEP_LAST   = RENDER_END + 8;
	localparam int NUM_LINES    = 6;
	localparam int WATCHDOG_CYCLES =
		NUM_LINES * (FETCH_BOUND + SWEEP_LAST - SWEEP_FIRST + 40) + 300;

	logic         CLK;
	logic         RSTb;
	reg_addr_t    address;
	mem_word_t    data_in;
	logic         wr;
	logic         h_tick;
	pixel_coord_t display_x;
	pixel_coord_t display_y;
	color_index_t color_index;
	mem_addr_t    mem_addr;
	mem_word_t    mem_data;
	logic         rvalid;
	logic         rready = 1'b0;

	mem_word_t    mem [65536];
	logic [31:0]  rng_state;
	logic [31:0]  stall_state;
	logic         stall_en;
	logic         grant_armed;
	int           grant_delay;
	int           checks;
	int           errors;
	int           test_errors;
	int           tests_run;

	bg_renderer #(
		.RENDER_START (RENDER_START),
		.RENDER_END   (RENDER_END)
	) uut (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.address     (address),
		.data_in     (data_in),
		.wr          (wr),
		.h_tick      (h_tick),
		.display_x   (display_x),
		.display_y   (display_y),
		.color_index (color_index),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.rvalid      (rvalid),
		.rready      (rready)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// Burst words follow the address, so data is a plain lookup
	assign mem_data = mem[mem_addr];

	function automatic logic [15:0] lcg_next(inout logic [31:0] state);
		state = state * 32'd1664525 + 32'd1013904223;
		return state[31:16];
	endfunction

	// Memory arbiter, grants each request after 0 to MAX_STALL cycles
	always @(posedge CLK) begin
		#1;
		if (!RSTb || !rvalid) begin
			rready = 1'b0;
			grant_armed = 1'b0;
		end else begin
			if (!grant_armed) begin
				grant_armed = 1'b1;
				grant_delay = stall_en ? int'(lcg_next(stall_state) % 16'd4) : 0;
			end
			if (grant_delay == 0) begin
				rready = 1'b1;
				grant_armed = 1'b0;
			end else begin
				rready = 1'b0;
				grant_delay--;
			end
		end
	end

	task automatic step();
		@(posedge CLK);
		#1;
	endtask

	task automatic write_reg(input reg_addr_t a, input mem_word_t d);
		address = a;
		data_in = d;
		wr = 1'b1;
		step();
		wr = 1'b0;
	endtask

	task automatic set_layer(input bit second, input layer_cfg_t c);
		write_reg(second ? REG_CTRL2 : REG_CTRL1, {8'h00, c.pal_hi, 3'b000, c.enable});
		write_reg(second ? REG_SCROLL_X2 : REG_SCROLL_X1, c.scroll_x);
		write_reg(second ? REG_SCROLL_Y2 : REG_SCROLL_Y1, c.scroll_y);
		write_reg(second ? REG_MAP_ADDR2 : REG_MAP_ADDR1, c.map_addr);
		write_reg(second ? REG_SET_ADDR2 : REG_SET_ADDR1, c.set_addr);
	endtask

	function automatic layer_cfg_t random_layer(input bit scroll);
		layer_cfg_t c;
		logic [15:0] r;
		r = lcg_next(rng_state);
		c.enable   = 1'b1;
		c.pal_hi   = r[7:4];
		c.scroll_x = scroll ? lcg_next(rng_state) : 16'h0000;
		c.scroll_y = scroll ? lcg_next(rng_state) : 16'h0000;
		c.map_addr = lcg_next(rng_state);
		c.set_addr = lcg_next(rng_state);
		return c;
	endfunction

	// Byte index of tile k on a line, map rows are 128 tiles wide
	function automatic logic [16:0] map_index(input layer_cfg_t c, input int y, input int k);
		logic [15:0] y_pos;
		y_pos = c.scroll_y + 16'(y);
		return {c.map_addr, 1'b0} + 17'(y_pos[10:4]) * 17'd128
			+ 17'(c.scroll_x[10:4]) + 17'(k);
	endfunction

	function automatic logic [3:0] layer_nibble(input int x, input int y, input layer_cfg_t c);
		int          p;
		int          o;
		logic [15:0] y_pos;
		logic [16:0] idx;
		tile_num_t   tile;
		mem_word_t   word;
		mem_addr_t   daddr;
		p = (x + int'(c.scroll_x[3:0])) % 1024;
		o = p % 16;
		y_pos = c.scroll_y + 16'(y);
		idx = map_index(c, y, (p - RENDER_START) / 16);
		word = mem[idx[16:1]];
		tile = idx[0] ? word[15:8] : word[7:0];
		if (tile == TILE_TRANSPARENT)
			return 4'h0;
		// 64 words per tile, 4 per row, 4 pixels per word
		daddr = c.set_addr * 16'd4 + 16'(tile) * 16'd64
			+ 16'(y_pos[3:0]) * 16'd4 + 16'(o / 4);
		word = mem[daddr];
		return word[(o % 4) * 4 +: 4];
	endfunction

	function automatic color_index_t expected_color(input int x, input int y,
			input layer_cfg_t c1, input layer_cfg_t c2, input bit l2_fetched);
		logic [3:0] n1;
		logic [3:0] n2;
		n1 = layer_nibble(x, y, c1);
		n2 = l2_fetched ? layer_nibble(x, y, c2) : 4'h0;
		if (n1 != 4'h0 || !c2.enable)
			return {c1.pal_hi, n1};
		return {c2.pal_hi, n2};
	endfunction

	task automatic mark_transparent(input layer_cfg_t c, input int y);
		logic [16:0] idx;
		for (int k = 0; k < TILES; k++) begin
			idx = map_index(c, y, k);
			if (lcg_next(rng_state) % 16'd2 == 16'd0) begin
				if (idx[0])
					mem[idx[16:1]][15:8] = TILE_TRANSPARENT;
				else
					mem[idx[16:1]][7:0] = TILE_TRANSPARENT;
			end
		end
	endtask

	task automatic check_equal(input string what, input logic [7:0] expected,
			input logic [7:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			test_errors++;
			$display("error %s: expected %02h, actual %02h", what, expected, actual);
		end
	endtask

	task automatic pulse_tick(input int y);
		display_y = pixel_coord_t'(y);
		h_tick = 1'b1;
		step();
		h_tick = 1'b0;
	endtask

	// No done signal, so wait out the worst-case fetch time
	task automatic fetch_line(input int y);
		pulse_tick(y);
		repeat (FETCH_BOUND) step();
	endtask

	task automatic show_line(input string name, input int y, input layer_cfg_t c1,
			input layer_cfg_t c2, input bit l2_fetched);
		int n;
		n = 0;
		test_errors = 0;
		pulse_tick(y + 1);
		// color_index trails display_x by two cycles
		for (int x = SWEEP_FIRST; x <= SWEEP_LAST + 2; x++) begin
			if (x - 2 >= RENDER_START && x - 2 < RENDER_END - 16) begin
				check_equal($sformatf("%s x=%0d", name, x - 2),
					expected_color(x - 2, y, c1, c2, l2_fetched), color_index);
				n++;
			end
			display_x = pixel_coord_t'(x);
			step();
		end
		display_x = '0;
		tests_run++;
		$display("test %s: %0d pixels checked, %0d mismatches", name, n, test_errors);
	endtask

	initial begin
		layer_cfg_t c1;
		layer_cfg_t c2;
		layer_cfg_t off;
		int         y;
		CLK = 1'b0;
		RSTb = 1'b0;
		address = '0;
		data_in = '0;
		wr = 1'b0;
		h_tick = 1'b0;
		display_x = '0;
		display_y = '0;
		rng_state = 32'd5573;
		stall_state = 32'd5573;
		stall_en = 1'b0;
		grant_armed = 1'b0;
		grant_delay = 0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		for (int a = 0; a < 65536; a++)
			mem[a] = lcg_next(rng_state);
		repeat (5) @(posedge CLK);
		#1;
		RSTb = 1'b1;
		step();

		// Layer 1 alone, no scroll
		off = '0;
		c1 = random_layer(1'b0);
		y = int'(lcg_next(rng_state) % 16'd480);
		set_layer(1'b0, c1);
		set_layer(1'b1, off);
		fetch_line(y);
		show_line("single_layer", y, c1, off, 1'b0);

		c1 = random_layer(1'b1);
		y = int'(lcg_next(rng_state) % 16'd480);
		set_layer(1'b0, c1);
		fetch_line(y);
		show_line("scrolling", y, c1, off, 1'b0);

		c1 = random_layer(1'b1);
		y = int'(lcg_next(rng_state) % 16'd480);
		mark_transparent(c1, y);
		set_layer(1'b0, c1);
		fetch_line(y);
		show_line("transparent_tiles", y, c1, off, 1'b0);

		// Transparent layer 1 tiles let layer 2 through
		c1 = random_layer(1'b1);
		c2 = random_layer(1'b1);
		y = int'(lcg_next(rng_state) % 16'd480);
		mark_transparent(c1, y);
		set_layer(1'b0, c1);
		set_layer(1'b1, c2);
		fetch_line(y);
		show_line("two_layers", y, c1, c2, 1'b1);

		// Layer 2 skipped on the fetch, then shown again: its buffer must be empty
		off = c2;
		off.enable = 1'b0;
		y = y + 1;
		mark_transparent(c1, y);
		set_layer(1'b1, off);
		fetch_line(y);
		set_layer(1'b1, c2);
		show_line("clear_after_display", y, c1, c2, 1'b0);

		stall_en = 1'b1;
		c1 = random_layer(1'b1);
		c2 = random_layer(1'b1);
		y = int'(lcg_next(rng_state) % 16'd480);
		mark_transparent(c1, y);
		set_layer(1'b0, c1);
		set_layer(1'b1, c2);
		fetch_line(y);
		show_line("memory_stalls", y, c1, c2, 1'b1);
		stall_en = 1'b0;

		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests_run, checks, errors, uut.u_fetch.u_sva.fail_count);
		if (errors == 0 && uut.u_fetch.u_sva.fail_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: filelist.f
rtl/bg_geom_pkg.sv
rtl/bg_regs_pkg.sv
rtl/bg_reg_file.sv
rtl/tile_fetcher.sv
rtl/scanline_ram.sv
rtl/scanline_mixer.sv
rtl/bg_renderer.sv
testbench/bg_renderer_sva.sv
testbench/bg_renderer_tb.sv

// File: Makefile
# Verilator lint and simulation of the background renderer

VERILATOR ?= verilator
TOP       ?= bg_renderer_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
